/* src.f */
logic/icache_pkg.sv
logic/icache_bank_if.sv
logic/icache_tag_bank.sv
logic/icache_data_bank.sv
logic/icache_hit_select.sv
logic/icache_ctrl.sv
logic/icache_top.sv
tb/icache_asserts.sv
tb/tb_icache.sv

/* Bender.yml */
package:
  name: icache

sources:
  - logic/icache_pkg.sv
  - logic/icache_bank_if.sv
  - logic/icache_tag_bank.sv
  - logic/icache_data_bank.sv
  - logic/icache_hit_select.sv
  - logic/icache_ctrl.sv
  - logic/icache_top.sv
  - target: test
    files:
      - tb/icache_asserts.sv
      - tb/tb_icache.sv

/* tb/tb_icache.sv */
`timescale 1ns/1ns

module tb_icache;
    import icache_pkg::*;

    localparam int unsigned WAY_COUNT    = 2;
    localparam int unsigned LINE_COUNT   = 16;
    localparam int unsigned IDX_W        = $clog2(LINE_COUNT);
    localparam int unsigned TAG_W        = ADDR_WIDTH - OFFSET_BITS - IDX_W;
    localparam int unsigned LINE_TOTAL   = 2 ** (ADDR_WIDTH - OFFSET_BITS);
    localparam int unsigned DIRECTED_OPS = 50;
    localparam int unsigned RANDOM_OPS   = 200;
    localparam int unsigned FLUSH_OPS    = 1;
    localparam int unsigned TIMEOUT_CYCLES =
        (DIRECTED_OPS + RANDOM_OPS + FLUSH_OPS) * 60 + FLUSH_OPS * 100;

    logic                   clk_i = 1'b0;
    logic                   rst_ni;
    logic                   fetch_req_i;
    logic [ADDR_WIDTH-1:0]  fetch_addr_i;
    logic                   fetch_ack_o;
    logic [FETCH_WIDTH-1:0] fetch_data_o;
    logic                   fetch_error_o;
    logic                   refill_req_o;
    logic [ADDR_WIDTH-1:0]  refill_addr_o;
    logic                   refill_ack_i;
    logic [LINE_WIDTH-1:0]  refill_line_i;
    logic                   refill_error_i;
    logic                   flush_req_i;
    logic                   flush_ack_o;

    // Next level memory and the cache model
    logic [LINE_WIDTH-1:0] mem_line  [LINE_TOTAL];
    logic                  mem_err   [LINE_TOTAL];
    logic [1:0]            mem_delay [LINE_TOTAL];
    logic                  model_valid [WAY_COUNT][LINE_COUNT];
    logic [TAG_W-1:0]      model_tag   [WAY_COUNT][LINE_COUNT];
    int unsigned           model_rr    [LINE_COUNT];

    logic [ADDR_WIDTH-1:0] last_refill_addr;
    logic [ADDR_WIDTH-1:0] resident [$];
    int unsigned refill_cnt  = 0;
    int unsigned fetch_count = 0;
    int unsigned error_count = 0;
    int unsigned test_num    = 1;
    int unsigned test_errors = 0;
    int unsigned cycle_cnt   = 0;
    int          err_line;
    int unsigned refills_start;

    icache_top #(
        .WAY_COUNT  (WAY_COUNT),
        .LINE_COUNT (LINE_COUNT)
    ) i_icache_top (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .fetch_req_i    (fetch_req_i),
        .fetch_addr_i   (fetch_addr_i),
        .fetch_ack_o    (fetch_ack_o),
        .fetch_data_o   (fetch_data_o),
        .fetch_error_o  (fetch_error_o),
        .refill_req_o   (refill_req_o),
        .refill_addr_o  (refill_addr_o),
        .refill_ack_i   (refill_ack_i),
        .refill_line_i  (refill_line_i),
        .refill_error_i (refill_error_i),
        .flush_req_i    (flush_req_i),
        .flush_ack_o    (flush_ack_o)
    );

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the cache stopped answering", cycle_cnt);
            $display("Checks failed");
            $finish;
        end
    end

    // Memory answers a refill after 0 to 3 cycles
    always begin
        @(negedge clk_i);
        if (rst_ni && refill_req_o && !refill_ack_i) begin
            repeat (mem_delay[refill_addr_o >> OFFSET_BITS]) @(negedge clk_i);
            last_refill_addr = refill_addr_o;
            refill_line_i    = mem_line[refill_addr_o >> OFFSET_BITS];
            refill_error_i   = mem_err[refill_addr_o >> OFFSET_BITS];
            refill_ack_i     = 1'b1;
            refill_cnt++;
            while (refill_req_o) @(negedge clk_i);
            refill_ack_i   = 1'b0;
            refill_line_i  = '0;
            refill_error_i = 1'b0;
        end
    end

    task automatic log_error(input string msg);
        error_count++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    task automatic finish_test(input string name);
        $display("Test %0d %s: %0d errors", test_num, name, error_count - test_errors);
        test_num++;
        test_errors = error_count;
    endtask

    function automatic logic [ADDR_WIDTH-1:0] make_addr(input int unsigned tag,
                                                        input int unsigned idx,
                                                        input int unsigned word);
        return {TAG_W'(tag), IDX_W'(idx), OFFSET_BITS'(word * (FETCH_WIDTH / 8))};
    endfunction

    function automatic logic predict_hit(input logic [ADDR_WIDTH-1:0] addr);
        logic [IDX_W-1:0] idx;
        logic             found;
        idx   = addr[OFFSET_BITS +: IDX_W];
        found = 1'b0;
        for (int w = 0; w < WAY_COUNT; w++) begin
            if (model_valid[w][idx] && model_tag[w][idx] == addr[ADDR_WIDTH-1 -: TAG_W]) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // Refill goes to the round robin victim of the index
    task automatic record_fill(input logic [ADDR_WIDTH-1:0] addr);
        logic [IDX_W-1:0] idx;
        int unsigned      victim;
        idx    = addr[OFFSET_BITS +: IDX_W];
        victim = model_rr[idx];
        model_valid[victim][idx] = 1'b1;
        model_tag[victim][idx]   = addr[ADDR_WIDTH-1 -: TAG_W];
        model_rr[idx]            = (victim + 1) % WAY_COUNT;
    endtask

    task automatic forget_all();
        for (int i = 0; i < LINE_COUNT; i++) begin
            for (int w = 0; w < WAY_COUNT; w++) begin
                model_valid[w][i] = 1'b0;
            end
            model_rr[i] = 0;
        end
    endtask

    task automatic run_fetch(input logic [ADDR_WIDTH-1:0] addr);
        logic                   hit;
        logic                   exp_err;
        logic [FETCH_WIDTH-1:0] exp_word;
        logic [LINE_WIDTH-1:0]  line;
        logic [ADDR_WIDTH-1:0]  exp_refill;
        int unsigned            refills_before;
        int unsigned            wait_cycles;
        hit        = predict_hit(addr);
        line       = mem_line[addr >> OFFSET_BITS];
        exp_err    = mem_err[addr >> OFFSET_BITS];
        exp_word   = addr[WORD_SEL_BIT] ? line[LINE_WIDTH-1 -: FETCH_WIDTH] : line[FETCH_WIDTH-1:0];
        exp_refill = (addr >> OFFSET_BITS) << OFFSET_BITS;
        if (exp_err) begin
            exp_word = '0;
        end
        refills_before = refill_cnt;
        wait_cycles    = 0;
        fetch_addr_i   = addr;
        fetch_req_i    = 1'b1;
        do begin
            @(negedge clk_i);
            wait_cycles++;
        end while (!fetch_ack_o);
        if (fetch_data_o !== exp_word || fetch_error_o !== exp_err) begin
            log_error($sformatf("fetch 0x%h gave data 0x%h err %b, expected 0x%h err %b",
                                addr, fetch_data_o, fetch_error_o, exp_word, exp_err));
        end
        if (refill_cnt - refills_before != (hit ? 0 : 1)) begin
            log_error($sformatf("fetch 0x%h caused %0d refills, expected %0d",
                                addr, refill_cnt - refills_before, hit ? 0 : 1));
        end
        if (!hit && last_refill_addr !== exp_refill) begin
            log_error($sformatf("refill address 0x%h for fetch 0x%h", last_refill_addr, addr));
        end
        if (hit && wait_cycles - 1 != 3) begin
            log_error($sformatf("hit on 0x%h acknowledged after %0d cycles, expected 3",
                                addr, wait_cycles - 1));
        end
        fetch_req_i = 1'b0;
        do @(negedge clk_i); while (fetch_ack_o);
        if (fetch_data_o !== '0 || fetch_error_o !== 1'b0) begin
            log_error($sformatf("fetch response 0x%h not cleared after ack fell", fetch_data_o));
        end
        if (!hit) begin
            record_fill(addr);
        end
        fetch_count++;
    endtask

    task automatic run_flush();
        flush_req_i = 1'b1;
        do @(negedge clk_i); while (!flush_ack_o);
        flush_req_i = 1'b0;
        do @(negedge clk_i); while (flush_ack_o);
        forget_all();
    endtask

    initial begin
        rst_ni         = 1'b0;
        fetch_req_i    = 1'b0;
        fetch_addr_i   = '0;
        refill_ack_i   = 1'b0;
        refill_line_i  = '0;
        refill_error_i = 1'b0;
        flush_req_i    = 1'b0;
        void'($urandom(32'h8518a3f5));
        for (int i = 0; i < LINE_TOTAL; i++) begin
            mem_line[i]  = {$urandom, $urandom};
            mem_err[i]   = ($urandom_range(7, 0) == 0);
            mem_delay[i] = 2'($urandom_range(3, 0));
        end
        forget_all();
        repeat (2) @(negedge clk_i);
        rst_ni = 1'b1;

        // Idle outputs, then a cold fetch
        if (fetch_ack_o !== 1'b0 || refill_req_o !== 1'b0 || flush_ack_o !== 1'b0) begin
            log_error("handshake outputs not low after reset");
        end
        run_fetch(make_addr(9'h012, 4, 0));
        if (refill_cnt != 1) begin
            log_error($sformatf("first fetch saw %0d refills, expected 1", refill_cnt));
        end
        finish_test("reset and first fetch");

        for (int i = 0; i < 6; i++) begin
            run_fetch(ADDR_WIDTH'($urandom));
        end
        err_line = -1;
        for (int l = 256; l < LINE_TOTAL && err_line < 0; l++) begin
            if (mem_err[l]) begin
                err_line = l;
            end
        end
        if (err_line < 0) begin
            error_count++;
            $display("No memory line with the error flag set was found");
        end else begin
            run_fetch(ADDR_WIDTH'(err_line << OFFSET_BITS));
            run_fetch(ADDR_WIDTH'((err_line << OFFSET_BITS) + FETCH_WIDTH / 8));
        end
        finish_test("data and error words");

        run_fetch(make_addr(9'h1F0, 2, 0));
        run_fetch(make_addr(9'h1F0, 2, 0));
        run_fetch(make_addr(9'h1F0, 2, 1));
        finish_test("miss then hits");

        // One more tag than ways at a single index, then back in reverse
        for (int k = 0; k <= WAY_COUNT; k++) begin
            run_fetch(make_addr(9'h0A0 + k, 9, k % 2));
        end
        for (int k = WAY_COUNT; k >= 0; k--) begin
            run_fetch(make_addr(9'h0A0 + k, 9, 0));
        end
        finish_test("round robin eviction");

        for (int i = 0; i < RANDOM_OPS; i++) begin
            run_fetch(make_addr(9'h040 + $urandom_range(3, 0), $urandom_range(3, 0),
                                $urandom_range(1, 0)));
        end
        finish_test("random window");

        for (int i = 0; i < LINE_COUNT; i++) begin
            for (int w = 0; w < WAY_COUNT; w++) begin
                if (model_valid[w][i]) begin
                    resident.push_back({model_tag[w][i], IDX_W'(i), OFFSET_BITS'(0)});
                end
            end
        end
        run_flush();
        refills_start = refill_cnt;
        foreach (resident[i]) begin
            run_fetch(resident[i]);
        end
        if (refill_cnt - refills_start != resident.size()) begin
            log_error($sformatf("%0d refills after flush for %0d resident lines",
                                refill_cnt - refills_start, resident.size()));
        end
        finish_test("flush");

        error_count += i_icache_top.i_icache_asserts.fail_count;
        $display("%0d fetches, %0d refills, %0d errors", fetch_count, refill_cnt, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* tb/icache_asserts.sv */
`timescale 1ns/1ns

module icache_asserts (
    input logic                              clk_i,
    input logic                              rst_ni,
    input logic                              fetch_req_i,
    input logic                              fetch_ack_o,
    input logic                              refill_req_o,
    input logic                              refill_ack_i,
    input logic [icache_pkg::ADDR_WIDTH-1:0] refill_addr_o,
    input logic                              flush_ack_o
);
    import icache_pkg::*;

    int unsigned fail_count = 0;

    // Fetch ack is raised in answer to a pending request
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(fetch_ack_o) |-> $past(fetch_req_i))
    else begin
        fail_count++;
        $error("fetch_ack_o rose without fetch_req_i");
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        $fell(refill_req_o) |-> $past(refill_ack_i))
    else begin
        fail_count++;
        $error("refill_req_o fell before refill_ack_i");
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(flush_ack_o && fetch_ack_o))
    else begin
        fail_count++;
        $error("flush_ack_o and fetch_ack_o high together");
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        refill_req_o |-> (refill_addr_o[OFFSET_BITS-1:0] == '0))
    else begin
        fail_count++;
        $error("refill_addr_o not line aligned");
    end

endmodule

bind icache_top icache_asserts i_icache_asserts (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_req_i   (fetch_req_i),
    .fetch_ack_o   (fetch_ack_o),
    .refill_req_o  (refill_req_o),
    .refill_ack_i  (refill_ack_i),
    .refill_addr_o (refill_addr_o),
    .flush_ack_o   (flush_ack_o)
);

/* logic/icache_top.sv */
`timescale 1ns/1ns

module icache_top #(
    parameter int unsigned WAY_COUNT  = 2,
    parameter int unsigned LINE_COUNT = 16
) (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               fetch_req_i,
    input  logic [icache_pkg::ADDR_WIDTH-1:0]  fetch_addr_i,
    output logic                               fetch_ack_o,
    output logic [icache_pkg::FETCH_WIDTH-1:0] fetch_data_o,
    output logic                               fetch_error_o,
    output logic                               refill_req_o,
    output logic [icache_pkg::ADDR_WIDTH-1:0]  refill_addr_o,
    input  logic                               refill_ack_i,
    input  logic [icache_pkg::LINE_WIDTH-1:0]  refill_line_i,
    input  logic                               refill_error_i,
    input  logic                               flush_req_i,
    output logic                               flush_ack_o
);
    import icache_pkg::*;

    localparam int unsigned IdxW = $clog2(LINE_COUNT);
    localparam int unsigned TagW = ADDR_WIDTH - OFFSET_BITS - IdxW;
    localparam int unsigned WayW = (WAY_COUNT > 1) ? $clog2(WAY_COUNT) : 1;

    logic                                 flush_start;
    logic                                 init_done;
    logic [WAY_COUNT-1:0]                 way_hit;
    logic [WAY_COUNT-1:0]                 way_err;
    logic [WayW-1:0]                      victim;
    logic [WAY_COUNT-1:0][LINE_WIDTH-1:0] way_lines;
    logic                                 sel_hit;
    logic                                 sel_error;
    logic [FETCH_WIDTH-1:0]               sel_word;
    logic [TagW-1:0]                      lookup_tag;

    // Fetch address is held stable for the whole handshake
    assign lookup_tag = fetch_addr_i[ADDR_WIDTH-1 -: TagW];

    icache_bank_if #(
        .WAY_COUNT  (WAY_COUNT),
        .LINE_COUNT (LINE_COUNT)
    ) bank_if ();

    icache_ctrl #(
        .WAY_COUNT  (WAY_COUNT),
        .LINE_COUNT (LINE_COUNT)
    ) i_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .fetch_req_i    (fetch_req_i),
        .fetch_addr_i   (fetch_addr_i),
        .fetch_ack_o    (fetch_ack_o),
        .fetch_data_o   (fetch_data_o),
        .fetch_error_o  (fetch_error_o),
        .refill_req_o   (refill_req_o),
        .refill_addr_o  (refill_addr_o),
        .refill_ack_i   (refill_ack_i),
        .refill_line_i  (refill_line_i),
        .refill_error_i (refill_error_i),
        .flush_req_i    (flush_req_i),
        .flush_ack_o    (flush_ack_o),
        .flush_start_o  (flush_start),
        .init_done_i    (init_done),
        .hit_i          (sel_hit),
        .error_i        (sel_error),
        .word_i         (sel_word),
        .victim_i       (victim),
        .bank           (bank_if.ctrl)
    );

    icache_tag_bank #(
        .WAY_COUNT  (WAY_COUNT),
        .LINE_COUNT (LINE_COUNT)
    ) i_tag_bank (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_start_i (flush_start),
        .bank          (bank_if.tag),
        .lookup_tag_i  (lookup_tag),
        .hit_o         (way_hit),
        .err_o         (way_err),
        .victim_o      (victim),
        .init_done_o   (init_done)
    );

    icache_data_bank #(
        .WAY_COUNT  (WAY_COUNT),
        .LINE_COUNT (LINE_COUNT)
    ) i_data_bank (
        .clk_i   (clk_i),
        .bank    (bank_if.data),
        .lines_o (way_lines)
    );

    icache_hit_select #(
        .WAY_COUNT (WAY_COUNT)
    ) i_hit_select (
        .hit_i      (way_hit),
        .err_i      (way_err),
        .lines_i    (way_lines),
        .word_sel_i (fetch_addr_i[WORD_SEL_BIT]),
        .hit_o      (sel_hit),
        .error_o    (sel_error),
        .word_o     (sel_word)
    );

endmodule

/* logic/icache_ctrl.sv */
`timescale 1ns/1ns

module icache_ctrl #(
    parameter int unsigned WAY_COUNT  = 2,
    parameter int unsigned LINE_COUNT = 16
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                fetch_req_i,
    input  logic [icache_pkg::ADDR_WIDTH-1:0]   fetch_addr_i,
    output logic                                fetch_ack_o,
    output logic [icache_pkg::FETCH_WIDTH-1:0]  fetch_data_o,
    output logic                                fetch_error_o,
    output logic                                refill_req_o,
    output logic [icache_pkg::ADDR_WIDTH-1:0]   refill_addr_o,
    input  logic                                refill_ack_i,
    input  logic [icache_pkg::LINE_WIDTH-1:0]   refill_line_i,
    input  logic                                refill_error_i,
    input  logic                                flush_req_i,
    output logic                                flush_ack_o,
    output logic                                flush_start_o,
    input  logic                                init_done_i,
    input  logic                                hit_i,
    input  logic                                error_i,
    input  logic [icache_pkg::FETCH_WIDTH-1:0]  word_i,
    input  logic [((WAY_COUNT > 1) ? $clog2(WAY_COUNT) : 1)-1:0] victim_i,
    icache_bank_if.ctrl                         bank
);
    import icache_pkg::*;

    localparam int unsigned IdxW = $clog2(LINE_COUNT);
    localparam int unsigned TagW = ADDR_WIDTH - OFFSET_BITS - IdxW;

    localparam logic [2:0] ST_IDLE      = 3'd0;
    localparam logic [2:0] ST_LOOKUP    = 3'd1;
    localparam logic [2:0] ST_WAIT_READ = 3'd2;
    localparam logic [2:0] ST_RESPOND   = 3'd3;
    localparam logic [2:0] ST_REFILL    = 3'd4;
    localparam logic [2:0] ST_WRITE     = 3'd5;
    localparam logic [2:0] ST_FLUSH     = 3'd6;

    logic [2:0]             state_q;
    logic                   fetch_ack_q;
    logic [FETCH_WIDTH-1:0] data_q;
    logic                   ferr_q;
    logic                   refill_req_q;
    logic                   flush_ack_q;
    logic                   written_q;
    logic [LINE_WIDTH-1:0]  fill_line_q;
    logic                   fill_err_q;

    // A fetch takes priority over a flush in idle
    assign flush_start_o = (state_q == ST_IDLE) && init_done_i && !fetch_req_i && flush_req_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= ST_IDLE;
            fetch_ack_q  <= 1'b0;
            data_q       <= '0;
            ferr_q       <= 1'b0;
            refill_req_q <= 1'b0;
            flush_ack_q  <= 1'b0;
            written_q    <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (init_done_i && fetch_req_i) begin
                        state_q <= ST_LOOKUP;
                    end else if (flush_start_o) begin
                        state_q <= ST_FLUSH;
                    end
                end
                ST_LOOKUP: begin
                    state_q <= ST_WAIT_READ;
                end
                ST_WAIT_READ: begin
                    state_q <= hit_i ? ST_RESPOND : ST_REFILL;
                end
                ST_RESPOND: begin
                    // Bank results stay stable until the next read
                    if (!fetch_ack_q) begin
                        fetch_ack_q <= 1'b1;
                        data_q      <= word_i;
                        ferr_q      <= error_i;
                    end else if (!fetch_req_i) begin
                        fetch_ack_q <= 1'b0;
                        data_q      <= '0;
                        ferr_q      <= 1'b0;
                        state_q     <= ST_IDLE;
                    end
                end
                ST_REFILL: begin
                    if (!refill_req_q) begin
                        if (!refill_ack_i) begin
                            refill_req_q <= 1'b1;
                        end
                    end else if (refill_ack_i) begin
                        refill_req_q <= 1'b0;
                        state_q      <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    // Write once, then wait for memory to drop its ack
                    written_q <= 1'b1;
                    if (written_q && !refill_ack_i) begin
                        written_q <= 1'b0;
                        state_q   <= ST_LOOKUP;
                    end
                end
                ST_FLUSH: begin
                    if (!flush_ack_q) begin
                        flush_ack_q <= init_done_i;
                    end else if (!flush_req_i) begin
                        flush_ack_q <= 1'b0;
                        state_q     <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Refill payload captured with the memory ack
    always_ff @(posedge clk_i) begin
        if (state_q == ST_REFILL && refill_req_q && refill_ack_i) begin
            fill_line_q <= refill_line_i;
            fill_err_q  <= refill_error_i;
        end
    end

    always_comb begin
        bank.bank_en = 1'b0;
        bank.bank_we = 1'b0;
        bank.index   = fetch_addr_i[OFFSET_BITS +: IdxW];
        bank.way     = victim_i;
        bank.wtag    = fetch_addr_i[ADDR_WIDTH-1 -: TagW];
        bank.wline   = fill_line_q;
        bank.werror  = fill_err_q;
        if (state_q == ST_LOOKUP) begin
            bank.bank_en = 1'b1;
        end else if (state_q == ST_WRITE && !written_q) begin
            bank.bank_en = 1'b1;
            bank.bank_we = 1'b1;
        end
    end

    assign fetch_ack_o   = fetch_ack_q;
    assign fetch_data_o  = data_q;
    assign fetch_error_o = ferr_q;
    assign refill_req_o  = refill_req_q;
    assign refill_addr_o = {fetch_addr_i[ADDR_WIDTH-1:OFFSET_BITS], OFFSET_BITS'(0)};
    assign flush_ack_o   = flush_ack_q;

endmodule

/* logic/icache_hit_select.sv */
`timescale 1ns/1ns

module icache_hit_select #(
    parameter int unsigned WAY_COUNT = 2
) (
    input  logic [WAY_COUNT-1:0]                             hit_i,
    input  logic [WAY_COUNT-1:0]                             err_i,
    input  logic [WAY_COUNT-1:0][icache_pkg::LINE_WIDTH-1:0] lines_i,
    input  logic                                             word_sel_i,
    output logic                                             hit_o,
    output logic                                             error_o,
    output logic [icache_pkg::FETCH_WIDTH-1:0]               word_o
);
    import icache_pkg::*;

    localparam int unsigned WayW = (WAY_COUNT > 1) ? $clog2(WAY_COUNT) : 1;

    logic [WayW-1:0]                            sel_way;
    logic [WORDS_PER_LINE-1:0][FETCH_WIDTH-1:0] sel_words;

    // Lowest hitting way wins
    always_comb begin
        sel_way = '0;
        for (int w = WAY_COUNT - 1; w >= 0; w--) begin
            if (hit_i[w]) begin
                sel_way = WayW'(w);
            end
        end
    end

    assign hit_o     = |hit_i;
    assign error_o   = hit_o && err_i[sel_way];
    assign sel_words = lines_i[sel_way];

    // Erroneous lines give zero data
    assign word_o = (hit_o && !error_o) ? sel_words[word_sel_i] : '0;

endmodule

/* logic/icache_data_bank.sv */
`timescale 1ns/1ns

module icache_data_bank #(
    parameter int unsigned WAY_COUNT  = 2,
    parameter int unsigned LINE_COUNT = 16
) (
    input  logic clk_i,
    icache_bank_if.data bank,
    output logic [WAY_COUNT-1:0][icache_pkg::LINE_WIDTH-1:0] lines_o
);
    import icache_pkg::*;

    logic [LINE_WIDTH-1:0] line_q [WAY_COUNT][LINE_COUNT];

    // Refill writes a single way
    always_ff @(posedge clk_i) begin
        if (bank.bank_en && bank.bank_we) begin
            line_q[bank.way][bank.index] <= bank.wline;
        end
    end

    // All ways of one index are read side by side
    always_ff @(posedge clk_i) begin
        if (bank.bank_en && !bank.bank_we) begin
            for (int w = 0; w < WAY_COUNT; w++) begin
                lines_o[w] <= line_q[w][bank.index];
            end
        end
    end

endmodule

/* logic/icache_tag_bank.sv */
`timescale 1ns/1ns

module icache_tag_bank #(
    parameter int unsigned WAY_COUNT  = 2,
    parameter int unsigned LINE_COUNT = 16
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_start_i,
    icache_bank_if.tag           bank,
    input  logic [icache_pkg::ADDR_WIDTH-icache_pkg::OFFSET_BITS-$clog2(LINE_COUNT)-1:0]
                                 lookup_tag_i,
    output logic [WAY_COUNT-1:0] hit_o,
    output logic [WAY_COUNT-1:0] err_o,
    output logic [((WAY_COUNT > 1) ? $clog2(WAY_COUNT) : 1)-1:0] victim_o,
    output logic                 init_done_o
);
    import icache_pkg::*;

    localparam int unsigned IdxW   = $clog2(LINE_COUNT);
    localparam int unsigned TagW   = ADDR_WIDTH - OFFSET_BITS - IdxW;
    localparam int unsigned WayW   = (WAY_COUNT > 1) ? $clog2(WAY_COUNT) : 1;
    localparam int unsigned EntryW = TagW + ENTRY_META_BITS;

    logic [EntryW-1:0]    entry_q [WAY_COUNT][LINE_COUNT];
    logic [WayW-1:0]      rr_q    [LINE_COUNT];
    logic [IdxW:0]        init_cnt_q;
    logic                 clearing;
    logic [EntryW-1:0]    new_entry;
    logic [WayW-1:0]      rr_next;
    logic [WAY_COUNT-1:0] rd_hit;
    logic [WAY_COUNT-1:0] rd_err;

    // One index per cycle is cleared after reset or a flush
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            init_cnt_q <= '0;
        end else if (flush_start_i) begin
            init_cnt_q <= '0;
        end else if (clearing) begin
            init_cnt_q <= init_cnt_q + 1'b1;
        end
    end

    assign clearing    = (init_cnt_q != (IdxW + 1)'(LINE_COUNT));
    assign init_done_o = !clearing;

    always_comb begin
        new_entry = {ENTRY_META_BITS'(0), bank.wtag};
        new_entry[TagW + ENTRY_VALID_OFS] = 1'b1;
        new_entry[TagW + ENTRY_ERR_OFS]   = bank.werror;
    end

    // Round robin over the ways of one index
    assign rr_next = (rr_q[bank.index] == WayW'(WAY_COUNT - 1)) ? '0 : rr_q[bank.index] + 1'b1;

    always_ff @(posedge clk_i) begin
        if (clearing) begin
            for (int w = 0; w < WAY_COUNT; w++) begin
                entry_q[w][init_cnt_q[IdxW-1:0]] <= '0;
            end
            rr_q[init_cnt_q[IdxW-1:0]] <= '0;
        end else if (bank.bank_en && bank.bank_we) begin
            entry_q[bank.way][bank.index] <= new_entry;
            rr_q[bank.index]              <= rr_next;
        end
    end

    // Tag compare for all ways at the read index
    always_comb begin
        for (int w = 0; w < WAY_COUNT; w++) begin
            rd_hit[w] = entry_q[w][bank.index][TagW + ENTRY_VALID_OFS]
                && (entry_q[w][bank.index][TagW-1:0] == lookup_tag_i);
            rd_err[w] = rd_hit[w] && entry_q[w][bank.index][TagW + ENTRY_ERR_OFS];
        end
    end

    // Results hold until the next read
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hit_o    <= '0;
            err_o    <= '0;
            victim_o <= '0;
        end else if (bank.bank_en && !bank.bank_we) begin
            hit_o    <= rd_hit;
            err_o    <= rd_err;
            victim_o <= rr_q[bank.index];
        end
    end

endmodule

/* logic/icache_bank_if.sv */
`timescale 1ns/1ns

interface icache_bank_if #(
    parameter int unsigned WAY_COUNT  = 2,
    parameter int unsigned LINE_COUNT = 16
);
    import icache_pkg::*;

    localparam int unsigned IdxW = $clog2(LINE_COUNT);
    localparam int unsigned TagW = ADDR_WIDTH - OFFSET_BITS - IdxW;
    localparam int unsigned WayW = (WAY_COUNT > 1) ? $clog2(WAY_COUNT) : 1;

    // Shared access reads all ways or writes one way
    logic                  bank_en;
    logic                  bank_we;
    logic [IdxW-1:0]       index;
    logic [WayW-1:0]       way;
    logic [TagW-1:0]       wtag;
    logic [LINE_WIDTH-1:0] wline;
    logic                  werror;

    modport ctrl (
        output bank_en, bank_we, index, way, wtag, wline, werror
    );

    modport tag (
        input bank_en, bank_we, index, way, wtag, werror
    );

    modport data (
        input bank_en, bank_we, index, way, wline
    );

endinterface

/* logic/icache_pkg.sv */
package icache_pkg;

    // Byte address width of the fetch and refill ports
    localparam int unsigned ADDR_WIDTH = 16;

    // One fetch word and the line built from fetch words
    localparam int unsigned FETCH_WIDTH    = 32;
    localparam int unsigned WORDS_PER_LINE = 2;
    localparam int unsigned LINE_WIDTH     = FETCH_WIDTH * WORDS_PER_LINE;

    // Byte offset of an address within one line
    localparam int unsigned OFFSET_BITS = $clog2(LINE_WIDTH / 8);

    // Address bit picking the fetch word within a line
    localparam int unsigned WORD_SEL_BIT = $clog2(FETCH_WIDTH / 8);

    // Tag entry holds the tag in the low bits
    // and the flags directly above it
    localparam int unsigned ENTRY_ERR_OFS   = 0;
    localparam int unsigned ENTRY_VALID_OFS = 1;
    localparam int unsigned ENTRY_META_BITS = 2;

endpackage
